// File: hw/byte_decrypt.sv
`timescale 1ns/1ps
`include "loader_settings.svh"

module byte_decrypt (
    input  logic                clk,
    input  logic                rst,
    dl_bus_if.crypt_mp          bus,
    input  loader_pkg::region_e region,
    input  logic                idx_b19,
    output logic [7:0]          dec_byte
);
    import loader_pkg::*;

    logic       enable;
    logic       key_bit;
    logic       apply;
    logic [7:0] xored;

    always_ff @(posedge clk) begin
        if (rst || !bus.downloading) begin
            enable  <= 1'b0;
            key_bit <= 1'b0;
        end else if (bus.wr && !bus.ram && bus.addr == 25'(`LOADER_CFG_BYTE)) begin
            {enable, key_bit} <= bus.data[7:6];
        end
    end

    // each input bit picks a fixed pattern
    always_comb begin
        xored = 8'h00;
        if (bus.data[0])  xored = xored ^ 8'h04;
        if (bus.data[1])  xored = xored ^ 8'h21;
        if (bus.data[2])  xored = xored ^ 8'h01;
        if (!bus.data[3]) xored = xored ^ 8'h50;  // inverted sense
        if (bus.data[4])  xored = xored ^ 8'h40;
        if (bus.data[5])  xored = xored ^ 8'h06;
        if (bus.data[6])  xored = xored ^ 8'h08;
        if (!bus.data[7]) xored = xored ^ 8'h88;  // inverted sense
    end

    assign apply    = enable && region == cpu && idx_b19 && (bus.addr[0] != key_bit);
    assign dec_byte = apply ? xored : bus.data;

endmodule

// File: hw/dl_bus_if.sv
`timescale 1ns/1ps

interface dl_bus_if;
    logic [24:0] addr;
    logic [7:0]  data;
    logic        wr;          // one cycle strobe
    logic        ram;         // eeprom path instead of rom
    logic        downloading;

    modport ctrl_mp  (input addr, data, wr, ram, downloading);
    modport map_mp   (input addr);
    modport crypt_mp (input addr, data, wr, ram, downloading);
    modport dump_mp  (input addr, data, wr, ram);

endinterface

// File: hw/eeprom_dump.sv
`timescale 1ns/1ps
`include "loader_settings.svh"

module eeprom_dump (
    input  logic                         clk,
    input  logic                         rst,
    dl_bus_if.dump_mp                    bus,
    output logic [15:0]                  dump_din,
    output logic [`LOADER_EEPROM_AW-1:0] dump_addr,
    output logic                         dump_we,
    input  logic [15:0]                  dump_dout,
    output logic [7:0]                   data_to_sd
);
    logic ram_wr;

    assign ram_wr = bus.wr && bus.ram;

    always_ff @(posedge clk) begin
        if (rst) begin
            dump_we <= 1'b0;
        end else begin
            dump_we <= ram_wr;
        end
    end

    // odd bytes land in the upper half
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            if (bus.addr[0]) begin
                dump_din[15:8] <= bus.data;
            end else begin
                dump_din[7:0] <= bus.data;
            end
        end
    end

    assign dump_addr  = bus.addr[`LOADER_EEPROM_AW:1];
    assign data_to_sd = bus.addr[0] ? dump_dout[15:8] : dump_dout[7:0];

endmodule

// File: hw/load_ctrl.sv
`timescale 1ns/1ps
`include "loader_settings.svh"

module load_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    dl_bus_if.ctrl_mp                bus,
    output loader_pkg::start_table_t starts,
    input  loader_pkg::region_e      region,
    input  logic [21:0]              word_addr,
    input  logic [1:0]               bank,
    input  logic [1:0]               mask,
    input  logic [7:0]               dec_byte,
    output logic [21:0]              prog_addr,
    output logic [15:0]              prog_data,
    output logic [1:0]               prog_mask,
    output logic [1:0]               prog_ba,
    output logic                     prog_we,
    output logic                     prom_we,
    input  logic                     prog_rdy,
    output logic                     cfg_we,
    output logic                     kabuki_we,
    output logic                     busy
);
    import loader_pkg::*;

    logic       rom_wr;
    logic       is_start;
    logic       is_cfg;
    logic       is_kabuki;
    logic       is_payload;
    logic       pay_wr;
    logic [7:0] pre_data;
    logic [1:0] kabuki_sr;  // two cycle pulse
    logic       dl_seen;    // a download ended, clear pending
    logic       clearing;
    logic       clr_start;
    logic       clr_ack;
    logic       clr_last;

    assign rom_wr     = bus.wr && !bus.ram;
    assign is_start   = bus.addr < 25'(`LOADER_START_BYTES);
    assign is_cfg     = !is_start && bus.addr < 25'(`LOADER_REGSIZE + `LOADER_START_HEADER);
    assign is_kabuki  = bus.addr >= 25'(`LOADER_KABUKI_FIRST)
                     && bus.addr <= 25'(`LOADER_KABUKI_LAST);
    assign is_payload = bus.addr >= 25'(`LOADER_FULL_HEADER);
    assign pay_wr     = rom_wr && is_payload;

    assign clr_start = !rom_wr && !bus.downloading && dl_seen && !clearing;
    assign clr_ack   = clearing && prog_we && prog_rdy;
    assign clr_last  = &prog_addr[`LOADER_CLR_AW-1:0];

    assign prog_data = {2{pre_data}};
    assign kabuki_we = kabuki_sr[0];

    // strobes and busy
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we   <= 1'b0;
            prom_we   <= 1'b0;
            cfg_we    <= 1'b0;
            kabuki_sr <= 2'b00;
            busy      <= 1'b0;
            dl_seen   <= 1'b0;
            clearing  <= 1'b0;
        end else begin
            cfg_we    <= rom_wr && is_cfg;
            kabuki_sr <= (rom_wr && is_kabuki) ? 2'b11 : kabuki_sr >> 1;
            if (rom_wr) begin
                busy    <= 1'b1;
                dl_seen <= 1'b1;
                if (is_payload) begin
                    prog_we <= region != qsnd;
                    prom_we <= region == qsnd;
                end
            end else if (clr_start) begin
                prog_we  <= 1'b1;  // first clear word
                prom_we  <= 1'b0;
                clearing <= 1'b1;
                dl_seen  <= 1'b0;
            end else if (clearing) begin
                if (clr_ack) begin
                    prog_we <= 1'b0;
                    if (clr_last) begin
                        clearing <= 1'b0;
                        busy     <= 1'b0;
                    end
                end else if (!prog_we) begin
                    prog_we <= 1'b1;   // next word
                end
            end else begin
                if (prog_rdy) prog_we <= 1'b0;
                if (!bus.downloading) prom_we <= 1'b0;
            end
        end
    end

    // start table and write payload
    always_ff @(posedge clk) begin
        if (rom_wr && is_start) begin
            starts.bytes <= {bus.data, starts.bytes[7:1]};
        end
        if (pay_wr) begin
            prog_addr <= word_addr;
            pre_data  <= dec_byte;
            prog_ba   <= bank;
            prog_mask <= mask;
        end else if (clr_start) begin
            prog_addr <= 22'd0;
            pre_data  <= 8'h00;
            prog_ba   <= 2'd0;
            prog_mask <= 2'b00;  // both bytes written
        end else if (clr_ack && !clr_last) begin
            prog_addr <= prog_addr + 22'd1;
        end
    end

endmodule

// File: hw/loader_pkg.sv
package loader_pkg;

    // kilobyte starts, snd comes from header bytes 0 and 1
    typedef struct packed {
        logic [15:0] qsnd;
        logic [15:0] gfx;
        logic [15:0] pcm;
        logic [15:0] snd;
    } start_kb_t;

    // filled a byte at a time, read as region starts
    typedef union packed {
        logic [7:0][7:0] bytes;
        start_kb_t       kb;
    } start_table_t;

    typedef enum logic [2:0] {
        cpu  = 3'd0,
        snd  = 3'd1,
        pcm  = 3'd2,
        gfx  = 3'd3,
        qsnd = 3'd4
    } region_e;

    localparam logic [1:0] bank_cpu   = 2'd3;
    localparam logic [1:0] bank_gfx   = 2'd2;
    localparam logic [1:0] bank_other = 2'd1;

endpackage

// File: hw/loader_settings.svh
`ifndef LOADER_SETTINGS_SVH
`define LOADER_SETTINGS_SVH

// header layout in bytes
`define LOADER_START_BYTES   8
`define LOADER_START_HEADER  16
`define LOADER_REGSIZE       24
`define LOADER_FULL_HEADER   64

// kabuki key bytes, both ends included
`define LOADER_KABUKI_FIRST  48
`define LOADER_KABUKI_LAST   58

// bit 7 enables decryption, bit 6 is the key bit
`define LOADER_CFG_BYTE      39

// word offsets into the sdram
`define LOADER_CPU_OFFSET    22'h000000
`define LOADER_SND_OFFSET    22'h080000
`define LOADER_PCM_OFFSET    22'h100000
`define LOADER_GFX_OFFSET    22'h000000

`define LOADER_EEPROM_AW     7
`define LOADER_CLR_AW        8   // words cleared after a download

`endif

// File: hw/region_map.sv
`timescale 1ns/1ps
`include "loader_settings.svh"

module region_map (
    dl_bus_if.map_mp               bus,
    input  loader_pkg::start_table_t starts,
    output loader_pkg::region_e      region,
    output logic [21:0]              word_addr,
    output logic [1:0]               bank,
    output logic [1:0]               mask,      // active low
    output logic                     idx_b19
);
    import loader_pkg::*;

    logic [24:0] byte_idx;
    logic [15:0] kb_idx;
    logic [15:0] start_kb;
    logic [21:0] offset;
    logic [24:0] rel_idx;

    assign byte_idx = bus.addr - 25'(`LOADER_FULL_HEADER);  // header excluded
    assign kb_idx   = {1'b0, byte_idx[24:10]};
    assign idx_b19  = byte_idx[19];

    // starts are expected in increasing order
    always_comb begin
        if (kb_idx >= starts.kb.qsnd) begin
            region = qsnd;
        end else if (kb_idx >= starts.kb.gfx) begin
            region = gfx;
        end else if (kb_idx >= starts.kb.pcm) begin
            region = pcm;
        end else if (kb_idx >= starts.kb.snd) begin
            region = snd;
        end else begin
            region = cpu;
        end
    end

    always_comb begin
        start_kb = 16'd0;
        offset   = `LOADER_CPU_OFFSET;
        bank     = bank_other;
        case (region)
            cpu: bank = bank_cpu;
            snd: begin
                start_kb = starts.kb.snd;
                offset   = `LOADER_SND_OFFSET;
            end
            pcm: begin
                start_kb = starts.kb.pcm;
                offset   = `LOADER_PCM_OFFSET;
            end
            gfx: begin
                start_kb = starts.kb.gfx;
                offset   = `LOADER_GFX_OFFSET;
                bank     = bank_gfx;
            end
            default: ;
        endcase
    end

    assign rel_idx = byte_idx - {start_kb[14:0], 10'd0};

    // q-sound rom wraps inside 8 kB
    assign word_addr = (region == qsnd) ? {10'd0, byte_idx[12:1]} : rel_idx[22:1] + offset;
    assign mask      = bus.addr[0] ? 2'b01 : 2'b10;

endmodule

// File: hw/rom_loader.sv
`timescale 1ns/1ps
`include "loader_settings.svh"

module rom_loader (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         downloading,
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    input  logic                         ioctl_wr,
    input  logic                         ioctl_ram,
    output logic [7:0]                   ioctl_data2sd,
    output logic [21:0]                  prog_addr,
    output logic [15:0]                  prog_data,
    output logic [1:0]                   prog_mask,
    output logic [1:0]                   prog_ba,
    output logic                         prog_we,
    output logic                         prom_we,
    input  logic                         prog_rdy,
    output logic                         cfg_we,
    output logic                         kabuki_we,
    output logic                         busy,
    output logic [15:0]                  dump_din,
    input  logic [15:0]                  dump_dout,
    output logic [`LOADER_EEPROM_AW-1:0] dump_addr,
    output logic                         dump_we
);
    import loader_pkg::*;

    start_table_t starts;
    region_e      region;
    logic [21:0]  word_addr;
    logic [1:0]   bank;
    logic [1:0]   mask;
    logic         idx_b19;
    logic [7:0]   dec_byte;

    dl_bus_if bus ();

    assign bus.addr        = ioctl_addr;
    assign bus.data        = ioctl_data;
    assign bus.wr          = ioctl_wr;
    assign bus.ram         = ioctl_ram;
    assign bus.downloading = downloading;

    load_ctrl load_ctrl_inst (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.ctrl_mp),
        .starts    (starts),
        .region    (region),
        .word_addr (word_addr),
        .bank      (bank),
        .mask      (mask),
        .dec_byte  (dec_byte),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .prog_mask (prog_mask),
        .prog_ba   (prog_ba),
        .prog_we   (prog_we),
        .prom_we   (prom_we),
        .prog_rdy  (prog_rdy),
        .cfg_we    (cfg_we),
        .kabuki_we (kabuki_we),
        .busy      (busy)
    );

    region_map region_map_inst (
        .bus       (bus.map_mp),
        .starts    (starts),
        .region    (region),
        .word_addr (word_addr),
        .bank      (bank),
        .mask      (mask),
        .idx_b19   (idx_b19)
    );

    byte_decrypt byte_decrypt_inst (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus.crypt_mp),
        .region   (region),
        .idx_b19  (idx_b19),
        .dec_byte (dec_byte)
    );

    eeprom_dump eeprom_dump_inst (
        .clk        (clk),
        .rst        (rst),
        .bus        (bus.dump_mp),
        .dump_din   (dump_din),
        .dump_addr  (dump_addr),
        .dump_we    (dump_we),
        .dump_dout  (dump_dout),
        .data_to_sd (ioctl_data2sd)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module rom_loader_tb -o rom_loader_sim \
    && ./obj_dir/rom_loader_sim | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: sim.f
+incdir+hw
hw/loader_pkg.sv
hw/dl_bus_if.sv
hw/region_map.sv
hw/byte_decrypt.sv
hw/eeprom_dump.sv
hw/load_ctrl.sv
hw/rom_loader.sv
verification/clk_gen.sv
verification/rom_loader_tb.sv

// File: verification/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: verification/rom_loader_tb.sv
`timescale 1ns/1ps
`include "loader_settings.svh"

module rom_loader_tb;
    import loader_pkg::*;

    localparam int handshake_limit = 8;
    localparam int clear_limit     = (1 << `LOADER_CLR_AW) * 6 + 16;
    localparam int run_limit       = 16 + 64 * 8 + 32 * 16 + clear_limit + 64;

    logic        clk;
    logic        rst;
    logic        downloading;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    logic        ioctl_ram;
    logic [7:0]  ioctl_data2sd;
    logic [21:0] prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we;
    logic        prom_we;
    logic        prog_rdy;
    logic        cfg_we;
    logic        kabuki_we;
    logic        busy;
    logic [15:0] dump_din;
    logic [15:0] dump_dout;
    logic [`LOADER_EEPROM_AW-1:0] dump_addr;
    logic        dump_we;

    // kilobyte starts of snd, pcm, gfx, qsnd
    int          start_kb [4] = '{1024, 1280, 2048, 4096};
    logic [15:0] test_lfsr = 16'd18244;
    logic [15:0] resp_lfsr = 16'd18244;
    logic        crypt_en  = 1'b0;
    logic        crypt_key = 1'b0;

    clk_gen clk_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    rom_loader rom_loader_inst (
        .clk           (clk),
        .rst           (rst),
        .downloading   (downloading),
        .ioctl_addr    (ioctl_addr),
        .ioctl_data    (ioctl_data),
        .ioctl_wr      (ioctl_wr),
        .ioctl_ram     (ioctl_ram),
        .ioctl_data2sd (ioctl_data2sd),
        .prog_addr     (prog_addr),
        .prog_data     (prog_data),
        .prog_mask     (prog_mask),
        .prog_ba       (prog_ba),
        .prog_we       (prog_we),
        .prom_we       (prom_we),
        .prog_rdy      (prog_rdy),
        .cfg_we        (cfg_we),
        .kabuki_we     (kabuki_we),
        .busy          (busy),
        .dump_din      (dump_din),
        .dump_dout     (dump_dout),
        .dump_addr     (dump_addr),
        .dump_we       (dump_we)
    );

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(inout logic [15:0] state, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_step(state);
            val = (val << 1) | 32'(state[0]);
        end
    endtask

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            end_with_failure();
        end
    endtask

    // region codes 0 cpu, 1 snd, 2 pcm, 3 gfx, 4 qsnd
    function automatic int region_of(input int idx);
        int r;
        r = 0;
        for (int i = 0; i < 4; i++) begin
            if (idx / 1024 >= start_kb[i]) r = i + 1;
        end
        return r;
    endfunction

    function automatic logic [21:0] offset_of(input int r);
        case (r)
            0:       return `LOADER_CPU_OFFSET;
            1:       return `LOADER_SND_OFFSET;
            2:       return `LOADER_PCM_OFFSET;
            3:       return `LOADER_GFX_OFFSET;
            default: return 22'd0;
        endcase
    endfunction

    function automatic logic [21:0] expected_word(input int idx);
        int r;
        int base;
        r = region_of(idx);
        if (r == 4) return 22'((idx % 8192) / 2);   // 8 kB window
        base = (r == 0) ? 0 : start_kb[r - 1] * 1024;
        return 22'((idx - base) / 2) + offset_of(r);
    endfunction

    function automatic logic [1:0] expected_bank(input int r);
        if (r == 0) return bank_cpu;
        if (r == 3) return bank_gfx;
        return bank_other;
    endfunction

    function automatic logic [7:0] decrypt_byte(input logic [7:0] b);
        logic [7:0] pattern [8];
        logic [7:0] active_low;
        logic [7:0] x;
        pattern    = '{8'h04, 8'h21, 8'h01, 8'h50, 8'h40, 8'h06, 8'h08, 8'h88};
        active_low = 8'b1000_1000;   // bits 3 and 7 count when clear
        x = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (b[i] != active_low[i]) x = x ^ pattern[i];
        end
        return x;
    endfunction

    // sdram side acks each write after 0 to 3 cycles
    initial begin : sdram_responder
        int wait_cycles;
        prog_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                take_bits(resp_lfsr, 2, wait_cycles);
                repeat (wait_cycles) @(negedge clk);
                @(posedge clk);
                prog_rdy <= 1'b1;
                @(posedge clk);
                prog_rdy <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        repeat (run_limit) @(posedge clk);
        $display("timeout, tests still running after %0d cycles", run_limit);
        end_with_failure();
    end

    task automatic write_byte(input logic [24:0] addr, input logic [7:0] data, input logic ram);
        @(posedge clk);
        ioctl_addr <= addr;
        ioctl_data <= data;
        ioctl_ram  <= ram;
        ioctl_wr   <= 1'b1;
        @(posedge clk);
        ioctl_wr   <= 1'b0;
    endtask

    task automatic header_byte(input int a, input logic [7:0] value);
        int cfg_pulses;
        int kabuki_cycles;
        logic is_cfg;
        logic is_kabuki;
        cfg_pulses    = 0;
        kabuki_cycles = 0;
        is_cfg    = a >= `LOADER_START_BYTES && a <= `LOADER_CFG_BYTE;
        is_kabuki = a >= `LOADER_KABUKI_FIRST && a <= `LOADER_KABUKI_LAST;
        write_byte(25'(a), value, 1'b0);
        repeat (4) begin
            @(negedge clk);
            if (cfg_we) cfg_pulses++;
            if (kabuki_we) kabuki_cycles++;
            check("prog_we", 32'(prog_we), 32'd0);
            check("prom_we", 32'(prom_we), 32'd0);
        end
        check("busy", 32'(busy), 32'd1);
        check("cfg_we", 32'(cfg_pulses), is_cfg ? 32'd1 : 32'd0);
        check("kabuki_we", 32'(kabuki_cycles), is_kabuki ? 32'd2 : 32'd0);
    endtask

    task automatic payload_write(input int idx, input logic [7:0] data);
        int          r;
        int          cycles;
        logic [24:0] addr;
        logic [7:0]  exp_byte;
        logic [21:0] held_addr;
        logic        rdy_prev;
        addr     = 25'(idx + `LOADER_FULL_HEADER);
        r        = region_of(idx);
        exp_byte = data;
        if (crypt_en && r == 0 && idx[19] && (idx[0] != crypt_key)) begin
            exp_byte = decrypt_byte(data);
        end
        write_byte(addr, data, 1'b0);
        @(negedge clk);
        check("prog_addr", 32'(prog_addr), 32'(expected_word(idx)));
        check("prog_ba", 32'(prog_ba), 32'(expected_bank(r)));
        check("prog_mask", 32'(prog_mask), 32'((idx % 2 == 0) ? 2'b10 : 2'b01));
        check("prog_data", 32'(prog_data), 32'({exp_byte, exp_byte}));
        check("prom_we", 32'(prom_we), (r == 4) ? 32'd1 : 32'd0);
        check("prog_we", 32'(prog_we), (r == 4) ? 32'd0 : 32'd1);
        held_addr = prog_addr;
        rdy_prev  = 1'b0;
        cycles    = 0;
        while (prog_we) begin
            rdy_prev = prog_rdy;
            @(negedge clk);
            cycles++;
            if (cycles > handshake_limit) begin
                $display("prog_we was never released after prog_rdy");
                end_with_failure();
            end
            check("prog_addr", 32'(prog_addr), 32'(held_addr));
        end
        if (r != 4) check("prog_rdy", 32'(rdy_prev), 32'd1);   // released only after ack
    endtask

    task automatic reset_test();
        @(negedge clk);
        check("prog_we", 32'(prog_we), 32'd0);
        check("prom_we", 32'(prom_we), 32'd0);
        check("cfg_we", 32'(cfg_we), 32'd0);
        check("kabuki_we", 32'(kabuki_we), 32'd0);
        check("dump_we", 32'(dump_we), 32'd0);
        check("busy", 32'(busy), 32'd0);
    endtask

    task automatic header_test();
        int         rnd;
        logic [7:0] value;
        @(posedge clk);
        downloading <= 1'b1;
        for (int a = 0; a < `LOADER_FULL_HEADER; a++) begin
            take_bits(test_lfsr, 8, rnd);
            value = 8'(rnd);
            if (a < `LOADER_START_BYTES) begin
                value = 8'(start_kb[a / 2] >> (8 * (a % 2)));   // little endian starts
            end else if (a == `LOADER_CFG_BYTE) begin
                value = value & 8'h3F;   // decryption off for now
            end
            header_byte(a, value);
        end
    endtask

    task automatic region_test();
        int order [5];
        int span_bits [5];
        int r;
        int base_kb;
        int offset;
        int data;
        order     = '{0, 1, 2, 4, 3};   // gfx last so prom_we drops again
        span_bits = '{20, 18, 19, 21, 16};
        for (int k = 0; k < 5; k++) begin
            r = order[k];
            base_kb = (r == 0) ? 0 : start_kb[r - 1];
            repeat (4) begin
                take_bits(test_lfsr, span_bits[r], offset);
                take_bits(test_lfsr, 8, data);
                payload_write(base_kb * 1024 + offset, 8'(data));
            end
        end
    endtask

    task automatic decrypt_test();
        int low;
        int data;
        int idx;
        take_bits(test_lfsr, 6, data);
        header_byte(`LOADER_CFG_BYTE, 8'hC0 | 8'(data));   // enable with key bit 1
        crypt_en  = 1'b1;
        crypt_key = 1'b1;
        for (int i = 0; i < 8; i++) begin
            take_bits(test_lfsr, 19, low);
            take_bits(test_lfsr, 8, data);
            idx = low & ~1;
            if (i[0]) idx = idx | 1;
            if (i[1]) idx = idx | 32'h80000;
            payload_write(idx, 8'(data));
        end
        // pcm bytes with bit 19 set stay plain
        repeat (2) begin
            take_bits(test_lfsr, 18, low);
            take_bits(test_lfsr, 8, data);
            payload_write(32'h180000 + low, 8'(data));
        end
    endtask

    task automatic clear_test();
        int next_addr;
        int cycles;
        @(negedge clk);
        check("busy", 32'(busy), 32'd1);
        @(posedge clk);
        downloading <= 1'b0;
        next_addr = 0;
        cycles    = 0;
        @(negedge clk);
        while (busy) begin
            if (prog_we && prog_rdy) begin
                check("prog_addr", 32'(prog_addr), 32'(next_addr));
                check("prog_data", 32'(prog_data), 32'd0);
                check("prog_mask", 32'(prog_mask), 32'd0);
                check("prog_ba", 32'(prog_ba), 32'd0);
                next_addr++;
            end
            check("prom_we", 32'(prom_we), 32'd0);
            @(negedge clk);
            cycles++;
            if (cycles > clear_limit) begin
                $display("ram clear did not finish, busy stayed high");
                end_with_failure();
            end
        end
        check("cleared words", 32'(next_addr), 32'(1 << `LOADER_CLR_AW));
        check("prog_we", 32'(prog_we), 32'd0);
        crypt_en = 1'b0;
    endtask

    task automatic eeprom_test();
        int a;
        int lo;
        int hi;
        int word;
        int word_index;
        logic [`LOADER_EEPROM_AW-1:0] exp_addr;
        take_bits(test_lfsr, `LOADER_EEPROM_AW + 1, a);
        take_bits(test_lfsr, 8, lo);
        take_bits(test_lfsr, 8, hi);
        a = a & ~1;
        word_index = a / 2;   // two bytes per eeprom word
        exp_addr = word_index[`LOADER_EEPROM_AW-1:0];
        write_byte(25'(a), 8'(lo), 1'b1);
        @(negedge clk);
        check("dump_we", 32'(dump_we), 32'd1);
        check("dump_din", 32'(dump_din[7:0]), 32'(8'(lo)));
        check("dump_addr", 32'(dump_addr), 32'(exp_addr));
        @(negedge clk);
        check("dump_we", 32'(dump_we), 32'd0);
        write_byte(25'(a + 1), 8'(hi), 1'b1);
        @(negedge clk);
        check("dump_we", 32'(dump_we), 32'd1);
        check("dump_din", 32'(dump_din), 32'({8'(hi), 8'(lo)}));
        check("dump_addr", 32'(dump_addr), 32'(exp_addr));
        check("busy", 32'(busy), 32'd0);   // eeprom writes are not rom writes
        @(negedge clk);
        check("dump_we", 32'(dump_we), 32'd0);
        // read back path
        take_bits(test_lfsr, 16, word);
        @(posedge clk);
        dump_dout  <= 16'(word);
        ioctl_addr <= 25'(a);
        @(negedge clk);
        check("ioctl_data2sd", 32'(ioctl_data2sd), 32'(word[7:0]));
        @(posedge clk);
        ioctl_addr <= 25'(a + 1);
        @(negedge clk);
        check("ioctl_data2sd", 32'(ioctl_data2sd), 32'(word[15:8]));
    endtask

    initial begin
        downloading = 1'b0;
        ioctl_addr  = 25'd0;
        ioctl_data  = 8'd0;
        ioctl_wr    = 1'b0;
        ioctl_ram   = 1'b0;
        dump_dout   = 16'd0;
        wait (rst === 1'b0);
        reset_test();
        header_test();
        region_test();
        decrypt_test();
        clear_test();
        eeprom_test();
        $display("Test completed successfully");
        $finish;
    end

endmodule
